// File: io_ports.f
+incdir+source
source/io_ports_pkg.sv
source/uart_tx.sv
source/gpio.sv
source/interrupt_controller.sv
source/scratch_ram.sv
source/port_controller.sv
sim/io_ports_checker.sv
sim/tb_io_ports.sv

// File: run_sim.sh
#!/bin/sh
# build the io_ports testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_io_ports -f io_ports.f -o tb_io_ports || exit 1

out=$(./obj_dir/tb_io_ports 2>&1)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// File: sim/io_ports_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module io_ports_checker (
	input  wire                         CLK,
	input  wire                         RSTb,
	input  wire io_ports_pkg::wb_req_t  bus_req,
	input  wire io_ports_pkg::wb_rsp_t  bus_rsp,
	input  wire                         uart_tx,
	input  wire  [`GPIO_OUT_W-1:0]      gpio_out,
	input  wire  [`GPIO_IN_W-1:0]       gpio_in,
	input  wire                         interrupt,
	input  wire io_ports_pkg::irq_src_t irq,
	input  wire  [7:0]                  test_num,
	input  wire                         test_done,
	output int                          check_count,
	output int                          error_count
);
	import io_ports_pkg::*;

	localparam int FRAME_CLKS = 10 * `UART_CLKS_PER_BIT;  // start, 8 data, stop
	localparam int HALF_BIT   = `UART_CLKS_PER_BIT / 2;

	// reference model, all values as seen just before a rising edge
	io_word_t               mem_m [1 << `SCRATCH_AWIDTH];
	logic [`GPIO_OUT_W-1:0] out_m;
	logic [`GPIO_IN_W-1:0]  mask_m;
	logic [`GPIO_IN_W-1:0]  sync1_m;
	logic [`GPIO_IN_W-1:0]  sync2_m;
	logic [`GPIO_IN_W-1:0]  prev_m;
	logic                   edge_m;    // gpio pulse in flight
	logic                   done_m;    // uart done pulse in flight
	irq_src_t               pend_m;
	irq_src_t               en_m;
	int                     uart_left; // clocks left in the current frame
	logic [7:0]             tx_byte_m;

	logic     acc_pend;  // access waiting for its ack
	logic     acc_we;
	io_addr_t acc_adr;
	io_word_t acc_exp;

	logic       rx_active;
	logic       rx_prev;
	int         rx_cnt;
	logic [9:0] rx_bits;
	int         frames_started;
	int         frames_seen;
	int         errors_before;

	function automatic io_word_t expected_read(input io_addr_t adr);
		io_word_t  v;
		reg_addr_t off;
		v   = '0;
		off = adr[3:0];
		case (adr[15:12])
			`IO_SEL_UART: v[0] = (off == `UART_REG_STATUS) && (uart_left != 0);
			`IO_SEL_GPIO: begin
				if (off == `GPIO_REG_OUT)
					v = io_word_t'(out_m);
				else if (off == `GPIO_REG_IN)
					v = io_word_t'(sync2_m);
				else if (off == `GPIO_REG_MASK)
					v = io_word_t'(mask_m);
			end
			`IO_SEL_INTC: begin
				if (off == `INTC_REG_PENDING)
					v = io_word_t'(pend_m);
				else if (off == `INTC_REG_ENABLE)
					v = io_word_t'(en_m);
			end
			`IO_SEL_SCRATCH: begin
				if (adr[11:`SCRATCH_AWIDTH] == '0)
					v = mem_m[adr[`SCRATCH_AWIDTH-1:0]];
			end
			default: ;  // unmapped
		endcase
		return v;
	endfunction

	task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	always @(posedge CLK) begin
		logic                  accept;
		logic [`GPIO_IN_W-1:0] rise;
		irq_src_t              clear;
		int                    left_pre;
		if (!RSTb) begin
			out_m          = '0;
			mask_m         = '0;
			sync1_m        = '0;
			sync2_m        = '0;
			prev_m         = '0;
			edge_m         = 1'b0;
			done_m         = 1'b0;
			pend_m         = '0;
			en_m           = '0;
			uart_left      = 0;
			acc_pend       = 1'b0;
			rx_active      = 1'b0;
			rx_prev        = 1'b1;
			frames_started = 0;
			frames_seen    = 0;
			check_count    = 0;
			error_count    = 0;
			errors_before  = 0;
		end else begin
			compare("gpio_out", 16'(gpio_out), 16'(out_m));
			compare("interrupt", 16'(interrupt), 16'(|(pend_m & en_m)));
			compare("irq", 16'(irq), 16'(pend_m & en_m));

			if (acc_pend) begin
				if (!bus_rsp.ack) begin
					error_count++;
					$display("error at %0t: no ack one cycle after the access to %h", $time, acc_adr);
				end else if (!acc_we) begin
					compare($sformatf("read %h", acc_adr), bus_rsp.dat, acc_exp);
				end
			end else if (bus_rsp.ack) begin
				error_count++;
				$display("error at %0t: ack without an outstanding access", $time);
			end

			accept   = bus_req.cyc && bus_req.stb && !bus_rsp.ack;
			acc_pend = accept;
			acc_we   = bus_req.we;
			acc_adr  = bus_req.adr;
			acc_exp  = expected_read(bus_req.adr);
			left_pre = uart_left;

			// interrupt sources, each one clock behind its cause
			rise  = sync2_m & ~prev_m & mask_m;
			clear = '0;
			if (accept && bus_req.we && bus_req.adr[15:12] == `IO_SEL_INTC
					&& bus_req.adr[3:0] == `INTC_REG_PENDING)
				clear = bus_req.dat[1:0];
			pend_m = (pend_m & ~clear) | {done_m, edge_m};
			edge_m = |rise;
			done_m = (left_pre == 1);
			if (uart_left != 0)
				uart_left--;
			prev_m  = sync2_m;
			sync2_m = sync1_m;
			sync1_m = gpio_in;

			if (accept && bus_req.we) begin
				case (bus_req.adr[15:12])
					`IO_SEL_UART: begin
						if (bus_req.adr[3:0] == `UART_REG_DATA && left_pre == 0) begin
							uart_left = FRAME_CLKS;
							tx_byte_m = bus_req.dat[7:0];
							frames_started++;
						end
					end
					`IO_SEL_GPIO: begin
						if (bus_req.adr[3:0] == `GPIO_REG_OUT)
							out_m = bus_req.dat[`GPIO_OUT_W-1:0];
						else if (bus_req.adr[3:0] == `GPIO_REG_MASK)
							mask_m = bus_req.dat[`GPIO_IN_W-1:0];
					end
					`IO_SEL_INTC: begin
						if (bus_req.adr[3:0] == `INTC_REG_ENABLE)
							en_m = bus_req.dat[1:0];
					end
					`IO_SEL_SCRATCH: begin
						if (bus_req.adr[11:`SCRATCH_AWIDTH] == '0)
							mem_m[bus_req.adr[`SCRATCH_AWIDTH-1:0]] = bus_req.dat;
					end
					default: ;
				endcase
			end

			// serial line, sampled mid-bit after the falling start edge
			if (!rx_active) begin
				if (rx_prev && !uart_tx) begin
					rx_active = 1'b1;
					rx_cnt    = 0;
				end
			end else begin
				rx_cnt++;
				if (rx_cnt % `UART_CLKS_PER_BIT == HALF_BIT) begin
					rx_bits = {uart_tx, rx_bits[9:1]};
					if (rx_cnt / `UART_CLKS_PER_BIT == 9) begin
						rx_active = 1'b0;
						frames_seen++;
						compare("uart frame", 16'(rx_bits), 16'({1'b1, tx_byte_m, 1'b0}));
					end
				end
			end
			rx_prev = uart_tx;

			if (test_done) begin
				if (frames_seen != frames_started) begin
					error_count++;
					$display("error at %0t: %0d uart frames started but %0d received",
						$time, frames_started, frames_seen);
				end
				$display("test %0d finished with %0d errors", test_num,
					error_count - errors_before);
				errors_before = error_count;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_io_ports.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module tb_io_ports;
	import io_ports_pkg::*;

	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 16;
	localparam int TEST_COUNT    = 6;
	localparam int CLKS_PER_TEST = 4000;  // a uart frame is 80 clocks
	localparam int ACK_WAIT      = 8;
	localparam logic [31:0] SEED = 32'h24668d03;

	localparam io_addr_t UART_DATA    = {`IO_SEL_UART, 8'h00, `UART_REG_DATA};
	localparam io_addr_t UART_STATUS  = {`IO_SEL_UART, 8'h00, `UART_REG_STATUS};
	localparam io_addr_t GPIO_OUT     = {`IO_SEL_GPIO, 8'h00, `GPIO_REG_OUT};
	localparam io_addr_t GPIO_IN      = {`IO_SEL_GPIO, 8'h00, `GPIO_REG_IN};
	localparam io_addr_t GPIO_MASK    = {`IO_SEL_GPIO, 8'h00, `GPIO_REG_MASK};
	localparam io_addr_t INTC_PENDING = {`IO_SEL_INTC, 8'h00, `INTC_REG_PENDING};
	localparam io_addr_t INTC_ENABLE  = {`IO_SEL_INTC, 8'h00, `INTC_REG_ENABLE};

	typedef logic [`GPIO_IN_W-1:0] gpio_in_t;

	logic                   CLK;
	logic                   RSTb;
	wb_req_t                bus_req;
	wb_rsp_t                bus_rsp;
	logic                   uart_tx;
	logic [`GPIO_OUT_W-1:0] gpio_out;
	gpio_in_t               gpio_in;
	logic                   interrupt;
	irq_src_t               irq;
	logic [7:0]             test_num;
	logic                   test_done;
	int                     check_count;
	int                     error_count;
	int                     bus_errors;  // lost acks, stuck uart
	io_addr_t               scratch_adr [64];

	port_controller dut0 (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp),
		.uart_tx  (uart_tx),
		.gpio_out (gpio_out),
		.gpio_in  (gpio_in),
		.interrupt(interrupt),
		.irq      (irq)
	);

	io_ports_checker chk0 (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.bus_req    (bus_req),
		.bus_rsp    (bus_rsp),
		.uart_tx    (uart_tx),
		.gpio_out   (gpio_out),
		.gpio_in    (gpio_in),
		.interrupt  (interrupt),
		.irq        (irq),
		.test_num   (test_num),
		.test_done  (test_done),
		.check_count(check_count),
		.error_count(error_count)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic wait_ack(output io_word_t dat);
		int waited;
		waited = 1;
		@(negedge CLK);
		while (!bus_rsp.ack && waited < ACK_WAIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!bus_rsp.ack) begin
			bus_errors++;
			$display("error at %0t: the DUT never acknowledged address %h", $time, bus_req.adr);
		end
		dat = bus_rsp.dat;
		@(negedge CLK);  // stb stays up over the edge that samples ack
		bus_req = '0;  // back to idle
	endtask

	task automatic bus_write(input io_addr_t adr, input io_word_t dat);
		io_word_t ignored;
		@(negedge CLK);
		bus_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack(ignored);
	endtask

	task automatic bus_read(input io_addr_t adr, output io_word_t dat);
		@(negedge CLK);
		bus_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		wait_ack(dat);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge CLK);
	endtask

	task automatic drive_gpio(input gpio_in_t value);
		@(negedge CLK);
		gpio_in = value;
	endtask

	task automatic wait_uart_idle();
		io_word_t status;
		int       polls;
		status = 16'h0001;
		polls  = 0;
		while (status[0] && polls < 200) begin
			bus_read(UART_STATUS, status);
			polls++;
		end
		if (status[0]) begin
			bus_errors++;
			$display("error at %0t: uart still busy long after the frame should end", $time);
		end
	endtask

	task automatic finish_test();
		@(negedge CLK);
		test_done = 1'b1;
		@(negedge CLK);
		test_done = 1'b0;
	endtask

	initial begin
		int       i;
		io_word_t v;
		CLK        = 1'b0;
		RSTb       = 1'b0;
		bus_req    = '0;
		gpio_in    = '0;
		test_num   = '0;
		test_done  = 1'b0;
		bus_errors = 0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(negedge CLK);
		RSTb = 1'b1;

		test_num = 8'd1;  // scratch ram
		for (i = 0; i < 64; i++) begin
			scratch_adr[i] = {`IO_SEL_SCRATCH, 3'b000, 9'($urandom)};
			bus_write(scratch_adr[i], 16'($urandom));
		end
		for (i = 0; i < 64; i++)
			bus_read(scratch_adr[i], v);
		finish_test();

		test_num = 8'd2;  // ack timing and unmapped space
		for (i = 0; i < 16; i++) begin
			bus_read({4'(2 + i % 5), 12'($urandom)}, v);
			bus_write({4'(2 + i % 5), 12'($urandom)}, 16'($urandom));
			bus_read(16'h8200 + 16'($urandom % 32'h7e00), v);
		end
		// same low bits as a scratch word but above 0x81ff
		bus_write(scratch_adr[0] | 16'h0e00, 16'hdead);
		bus_read(scratch_adr[0], v);
		finish_test();

		test_num = 8'd3;  // gpio
		for (i = 0; i < 8; i++) begin
			bus_write(GPIO_OUT, 16'($urandom));
			bus_read(GPIO_OUT, v);
			drive_gpio(gpio_in_t'($urandom));
			idle(4);  // let the synchronizers settle
			bus_read(GPIO_IN, v);
		end
		bus_read(GPIO_MASK, v);
		finish_test();

		test_num = 8'd4;  // uart frames
		for (i = 0; i < 4; i++) begin
			bus_write(UART_DATA, 16'($urandom));
			bus_read(UART_STATUS, v);
			wait_uart_idle();
		end
		finish_test();

		test_num = 8'd5;  // interrupts
		bus_write(GPIO_MASK, 16'h003f);
		drive_gpio('0);
		idle(6);
		bus_write(INTC_PENDING, 16'h0003);  // leftovers from earlier frames
		bus_write(INTC_ENABLE, 16'h0003);
		drive_gpio(gpio_in_t'(1));
		idle(6);
		bus_read(INTC_PENDING, v);
		bus_write(INTC_PENDING, 16'h0001);
		bus_read(INTC_PENDING, v);
		bus_write(UART_DATA, 16'h00a5);
		wait_uart_idle();
		idle(4);
		bus_read(INTC_PENDING, v);
		bus_write(INTC_PENDING, 16'h0002);
		bus_write(INTC_ENABLE, 16'h0000);
		drive_gpio(gpio_in_t'(3));  // edge on bit 1 with nothing enabled
		idle(6);
		bus_read(INTC_PENDING, v);
		bus_write(INTC_PENDING, 16'h0003);
		bus_read(INTC_PENDING, v);
		finish_test();

		test_num = 8'd6;  // second write lands while busy
		bus_write(UART_DATA, 16'h003c);
		bus_write(UART_DATA, 16'h00c3);
		wait_uart_idle();
		finish_test();

		idle(2);
		$display("closing: %0d tests, %0d checks, %0d errors", TEST_COUNT, check_count,
			error_count + bus_errors);
		if (error_count == 0 && bus_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(TEST_COUNT * CLKS_PER_TEST * CLK_PERIOD);
		$display("run timed out after %0d clocks before all tests finished",
			TEST_COUNT * CLKS_PER_TEST);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/gpio.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module gpio (
	input  wire                         CLK,
	input  wire                         RSTb,
	input  wire io_ports_pkg::reg_addr_t reg_addr,
	input  wire io_ports_pkg::io_word_t  wdata,
	input  wire                         wr,
	output io_ports_pkg::io_word_t      rdata,
	output logic [`GPIO_OUT_W-1:0]      pins_out,
	input  wire  [`GPIO_IN_W-1:0]       pins_in,
	output logic                        edge_int
);
	import io_ports_pkg::*;

	logic [`GPIO_IN_W-1:0] sync1_q;
	logic [`GPIO_IN_W-1:0] sync2_q;
	logic [`GPIO_IN_W-1:0] prev_q;    // for edge detect
	logic [`GPIO_IN_W-1:0] mask_q;
	logic [`GPIO_IN_W-1:0] rising;

	assign rising = sync2_q & ~prev_q & mask_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pins_out <= '0;
			mask_q   <= '0;
			sync1_q  <= '0;
			sync2_q  <= '0;
			prev_q   <= '0;
			edge_int <= 1'b0;
		end else begin
			sync1_q  <= pins_in;
			sync2_q  <= sync1_q;
			prev_q   <= sync2_q;
			edge_int <= |rising;
			if (wr && reg_addr == `GPIO_REG_OUT)
				pins_out <= wdata[`GPIO_OUT_W-1:0];
			if (wr && reg_addr == `GPIO_REG_MASK)
				mask_q <= wdata[`GPIO_IN_W-1:0];
		end
	end

	always_comb begin
		rdata = '0;
		case (reg_addr)
			`GPIO_REG_OUT:  rdata = io_word_t'(pins_out);
			`GPIO_REG_IN:   rdata = io_word_t'(sync2_q);
			`GPIO_REG_MASK: rdata = io_word_t'(mask_q);
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module interrupt_controller (
	input  wire                         CLK,
	input  wire                         RSTb,
	input  wire io_ports_pkg::reg_addr_t reg_addr,
	input  wire io_ports_pkg::io_word_t  wdata,
	input  wire                         wr,
	output io_ports_pkg::io_word_t      rdata,
	input  wire io_ports_pkg::irq_src_t  sources,
	output logic                        interrupt,
	output io_ports_pkg::irq_src_t      active
);
	import io_ports_pkg::*;

	irq_src_t pending_q;
	irq_src_t enable_q;
	irq_src_t clear;

	// write one to clear
	assign clear = (wr && reg_addr == `INTC_REG_PENDING) ?
		wdata[$bits(irq_src_t)-1:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending_q <= '0;
			enable_q  <= '0;
		end else begin
			pending_q <= (pending_q & ~clear) | sources; // new pulse beats the clear
			if (wr && reg_addr == `INTC_REG_ENABLE)
				enable_q <= wdata[$bits(irq_src_t)-1:0];
		end
	end

	assign active    = pending_q & enable_q;
	assign interrupt = |active;

	always_comb begin
		rdata = '0;
		case (reg_addr)
			`INTC_REG_PENDING: rdata = io_word_t'(pending_q);
			`INTC_REG_ENABLE:  rdata = io_word_t'(enable_q);
			default: ;
		endcase
	end

	a_masked: assert property (@(posedge CLK) disable iff (!RSTb)
		(enable_q == '0) |-> !interrupt)
		else $error("interrupt raised with all sources disabled");

endmodule

`default_nettype wire

// File: source/io_ports_defines.svh
`ifndef IO_PORTS_DEFINES_SVH
`define IO_PORTS_DEFINES_SVH

// upper address nibble of each peripheral
`define IO_SEL_UART     4'h0
`define IO_SEL_GPIO     4'h1
`define IO_SEL_INTC     4'h7
`define IO_SEL_SCRATCH  4'h8

`define SCRATCH_AWIDTH  9   // 512 words at 0x8000
`define GPIO_OUT_W      4
`define GPIO_IN_W       6

`define UART_CLKS_PER_BIT 8

// register offsets, low address bits
`define UART_REG_DATA     4'd0
`define UART_REG_STATUS   4'd1
`define GPIO_REG_OUT      4'd0
`define GPIO_REG_IN       4'd1
`define GPIO_REG_MASK     4'd2
`define INTC_REG_PENDING  4'd0
`define INTC_REG_ENABLE   4'd1

`endif

// File: source/io_ports_pkg.sv
`default_nettype none

package io_ports_pkg;

	typedef logic [15:0] io_word_t;   // data word
	typedef logic [15:0] io_addr_t;   // port address
	typedef logic [3:0]  reg_addr_t;  // register offset inside a peripheral

	// bit 0 gpio edge, bit 1 uart done
	typedef logic [1:0] irq_src_t;

	// request from the cpu, held until ack
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		io_addr_t adr;
		io_word_t dat;
	} wb_req_t;

	typedef struct packed {
		io_word_t dat;
		logic     ack;
	} wb_rsp_t;

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} uart_state_t;

endpackage

`default_nettype wire

// File: source/port_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module port_controller (
	input  wire                       CLK,
	input  wire                       RSTb,
	input  wire io_ports_pkg::wb_req_t bus_req,
	output io_ports_pkg::wb_rsp_t     bus_rsp,
	output logic                      uart_tx,
	output logic [`GPIO_OUT_W-1:0]    gpio_out,
	input  wire  [`GPIO_IN_W-1:0]     gpio_in,
	output logic                      interrupt,
	output io_ports_pkg::irq_src_t    irq
);
	import io_ports_pkg::*;

	logic      new_req;
	logic [3:0] nibble;
	logic      scratch_hit;
	reg_addr_t reg_addr;

	logic wr_uart;
	logic wr_gpio;
	logic wr_intc;
	logic wr_scratch;

	io_word_t rdata_uart;
	io_word_t rdata_gpio;
	io_word_t rdata_intc;
	io_word_t rdata_scratch;
	io_word_t dout_next;
	io_word_t dout_q;

	logic       scratch_q;  // access being acknowledged hit the ram
	logic       ack_q;

	logic gpio_int;
	logic tx_done;

	// no new access while ack is out, so one ack per stb
	assign new_req     = bus_req.cyc & bus_req.stb & ~ack_q;
	assign nibble      = bus_req.adr[15:12];
	assign scratch_hit = (bus_req.adr[11:`SCRATCH_AWIDTH] == '0); // 0x8000-0x81ff only
	assign reg_addr    = bus_req.adr[$bits(reg_addr_t)-1:0];

	always_comb begin
		wr_uart    = 1'b0;
		wr_gpio    = 1'b0;
		wr_intc    = 1'b0;
		wr_scratch = 1'b0;
		dout_next  = '0;
		case (nibble)
			`IO_SEL_UART: begin
				dout_next = rdata_uart;
				wr_uart   = new_req & bus_req.we;
			end
			`IO_SEL_GPIO: begin
				dout_next = rdata_gpio;
				wr_gpio   = new_req & bus_req.we;
			end
			`IO_SEL_INTC: begin
				dout_next = rdata_intc;
				wr_intc   = new_req & bus_req.we;
			end
			`IO_SEL_SCRATCH: begin
				wr_scratch = new_req & bus_req.we & scratch_hit;
			end
			default: ;  // unmapped, reads zero
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ack_q     <= 1'b0;
			scratch_q <= 1'b0;
		end else begin
			ack_q <= new_req;
			if (new_req)
				scratch_q <= (nibble == `IO_SEL_SCRATCH) && scratch_hit;
		end
	end

	always_ff @(posedge CLK) begin
		if (new_req)
			dout_q <= dout_next;
	end

	// ram data is already one cycle late, same as the registered peripherals
	always_comb begin
		bus_rsp.ack = ack_q;
		bus_rsp.dat = dout_q;  // zero for unmapped space
		if (scratch_q)
			bus_rsp.dat = rdata_scratch;
	end

	uart_tx #(.CLKS_PER_BIT(`UART_CLKS_PER_BIT)) u0 (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.reg_addr(reg_addr),
		.wdata   (bus_req.dat),
		.wr      (wr_uart),
		.rdata   (rdata_uart),
		.txd     (uart_tx),
		.tx_done (tx_done)
	);

	gpio g0 (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.reg_addr(reg_addr),
		.wdata   (bus_req.dat),
		.wr      (wr_gpio),
		.rdata   (rdata_gpio),
		.pins_out(gpio_out),
		.pins_in (gpio_in),
		.edge_int(gpio_int)
	);

	interrupt_controller irq0 (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.reg_addr (reg_addr),
		.wdata    (bus_req.dat),
		.wr       (wr_intc),
		.rdata    (rdata_intc),
		.sources  ({tx_done, gpio_int}),
		.interrupt(interrupt),
		.active   (irq)
	);

	scratch_ram #(.AWIDTH(`SCRATCH_AWIDTH)) scr0 (
		.CLK  (CLK),
		.addr (bus_req.adr[`SCRATCH_AWIDTH-1:0]),
		.wdata(bus_req.dat),
		.we   (wr_scratch),
		.rdata(rdata_scratch)
	);

	a_single_ack: assert property (@(posedge CLK) disable iff (!RSTb)
		bus_rsp.ack |=> !bus_rsp.ack)
		else $error("ack high two cycles in a row");

	a_one_strobe: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({wr_uart, wr_gpio, wr_intc, wr_scratch}))
		else $error("more than one peripheral write strobe");

endmodule

`default_nettype wire

// File: source/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module scratch_ram #(
	parameter int AWIDTH = `SCRATCH_AWIDTH
) (
	input  wire                        CLK,
	input  wire  [AWIDTH-1:0]          addr,
	input  wire io_ports_pkg::io_word_t wdata,
	input  wire                        we,
	output io_ports_pkg::io_word_t     rdata
);
	import io_ports_pkg::*;

	localparam int DEPTH = 1 << AWIDTH;

	io_word_t mem [DEPTH];

	// read returns the old word on a same-cycle write
	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "io_ports_defines.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  wire                         CLK,
	input  wire                         RSTb,
	input  wire io_ports_pkg::reg_addr_t reg_addr,
	input  wire io_ports_pkg::io_word_t  wdata,
	input  wire                         wr,
	output io_ports_pkg::io_word_t      rdata,
	output logic                        txd,
	output logic                        tx_done
);
	import io_ports_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	uart_state_t      state_q;
	logic [CNT_W-1:0] clk_cnt_q;   // clocks inside the current bit
	logic [2:0]       bit_idx_q;
	logic [7:0]       shift_q;
	logic             bit_end;
	logic             busy;
	logic             start_req;

	assign busy      = (state_q != st_idle);
	assign bit_end   = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
	assign start_req = wr && (reg_addr == `UART_REG_DATA) && !busy; // dropped when busy

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_q   <= st_idle;
			txd       <= 1'b1;
			tx_done   <= 1'b0;
			clk_cnt_q <= '0;
		end else begin
			tx_done <= 1'b0;
			if (state_q != st_idle)
				clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
			case (state_q)
				st_idle: begin
					if (start_req) begin
						state_q   <= st_start;
						txd       <= 1'b0;
						clk_cnt_q <= '0;
					end
				end
				st_start: begin
					if (bit_end) begin
						state_q <= st_data;
						txd     <= shift_q[0];   // lsb first
					end
				end
				st_data: begin
					if (bit_end) begin
						if (bit_idx_q == 3'd7) begin
							state_q <= st_stop;
							txd     <= 1'b1;
						end else begin
							txd <= shift_q[1];
						end
					end
				end
				st_stop: begin
					if (bit_end) begin
						state_q <= st_idle;
						tx_done <= 1'b1;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge CLK) begin
		if (start_req) begin
			shift_q   <= wdata[7:0];
			bit_idx_q <= '0;
		end else if (state_q == st_data && bit_end) begin
			shift_q   <= shift_q >> 1;
			bit_idx_q <= bit_idx_q + 1'b1;
		end
	end

	assign rdata = (reg_addr == `UART_REG_STATUS) ? {15'd0, busy} : '0;

	a_idle_high: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_q == st_idle) |-> txd)
		else $error("txd low while uart idle");

endmodule

`default_nettype wire
